// File: databus_axi.f
verilog/databus_pkg.sv
verilog/merged_bus_if.sv
verilog/databus_merge.sv
verilog/burst_axi_bridge.sv
verilog/databus_axi_top.sv
testbench/axi_mem_model.sv
testbench/tb_databus_axi.sv

// File: testbench/tb_databus_axi.sv
`timescale 1ns/10ps
`default_nettype none

module tb_databus_axi
  import databus_pkg::*;
#(
  parameter int N_UNITS = 2,
  parameter int ADDR_W  = DEFAULT_ADDR_W,
  parameter int DATA_W  = DEFAULT_DATA_W
) ();

  localparam int WAIT_LIMIT = 1000; // Cycles before a unit counts as hung

  logic                        clk, rst;
  logic [N_UNITS-1:0]          s_valid, s_ready, s_last;
  logic [N_UNITS*ADDR_W-1:0]   s_addr;
  logic [N_UNITS*DATA_W-1:0]   s_wdata;
  logic [N_UNITS*DATA_W/8-1:0] s_wstrb;
  logic [N_UNITS*8-1:0]        s_len;
  logic [DATA_W-1:0]           s_rdata;
  logic                        axi_awvalid, axi_awready, axi_wvalid, axi_wready, axi_wlast;
  logic                        axi_arvalid, axi_arready, axi_rvalid, axi_rready, axi_rlast;
  logic [ADDR_W-1:0]           axi_awaddr, axi_araddr;
  beat_len_t                   axi_awlen, axi_arlen;
  logic [DATA_W-1:0]           axi_wdata, axi_rdata;
  logic [DATA_W/8-1:0]         axi_wstrb;

  integer            seed = 55211;
  logic [31:0]       shadow [1024]; // Expected memory contents by word index
  logic [N_UNITS-1:0] rd_active;
  logic [ADDR_W-1:0] rd_addr [N_UNITS];
  int                rd_beat [N_UNITS];
  string             rd_name [N_UNITS];
  int                burst_len [N_UNITS]; // Requested beats minus one
  int                aw_unit;
  int                n;
  logic [31:0]       rnd;

  databus_axi_top #(.N_UNITS(N_UNITS), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_databus_axi_top (.*);

  axi_mem_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_axi_mem_model (
    .clk(clk), .rst(rst),
    .awvalid(axi_awvalid), .awready(axi_awready), .awaddr(axi_awaddr),
    .wvalid(axi_wvalid), .wready(axi_wready), .wdata(axi_wdata),
    .wstrb(axi_wstrb), .wlast(axi_wlast),
    .arvalid(axi_arvalid), .arready(axi_arready), .araddr(axi_araddr), .arlen(axi_arlen),
    .rvalid(axi_rvalid), .rready(axi_rready), .rdata(axi_rdata), .rlast(axi_rlast)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Bytewise merge of a write into the previous word
  function automatic logic [31:0] ref_word(input logic [31:0] old, input logic [31:0] data,
                                           input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic end_with_failure();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      end_with_failure();
    end
  endtask

  // One databus burst from unit u, write when strb is nonzero
  task automatic run_burst(input int u, input string name, input logic [ADDR_W-1:0] addr,
                           input int len, input logic [3:0] strb);
    int          beat;
    int          waited;
    logic [31:0] data;
    @(negedge clk);
    data = $random(seed);
    s_addr[u*ADDR_W +: ADDR_W] = addr;
    s_len[u*8 +: 8]            = len[7:0];
    s_wstrb[u*4 +: 4]          = strb;
    s_wdata[u*DATA_W +: DATA_W] = data;
    rd_addr[u]   = addr;
    rd_beat[u]   = 0;
    rd_name[u]   = name;
    burst_len[u] = len;
    rd_active[u] = (strb == 4'h0);
    s_valid[u]   = 1'b1;
    beat   = 0;
    waited = 0;
    while (beat <= len) begin
      if (s_ready[u]) begin // Beat moves on the coming rising edge
        check({name, " s_last"}, beat == len, s_last[u]);
        if (strb != 4'h0) begin
          shadow[addr[11:2] + beat] = ref_word(shadow[addr[11:2] + beat], data, strb);
        end
        beat   = beat + 1;
        waited = 0;
        @(negedge clk);
        data = $random(seed);
        s_wdata[u*DATA_W +: DATA_W] = data;
      end else begin
        waited = waited + 1;
        if (waited > WAIT_LIMIT) begin
          $display("unit %0d hung in %s, no s_ready for %0d cycles", u, name, WAIT_LIMIT);
          end_with_failure();
        end
        @(negedge clk);
      end
    end
    s_valid[u]   = 1'b0;
    rd_active[u] = 1'b0;
  endtask

  // Read data compare on every read beat
  always @(negedge clk) begin
    for (int u = 0; u < N_UNITS; u++) begin
      if (rd_active[u] && s_ready[u]) begin
        check($sformatf("%s beat %0d", rd_name[u], rd_beat[u]),
              shadow[rd_addr[u][11:2] + rd_beat[u]], s_rdata);
        rd_beat[u] = rd_beat[u] + 1;
      end
    end
  end

  // AW request must carry the address and length of a waiting write
  always @(negedge clk) begin
    if (!rst && axi_awvalid && axi_awready) begin
      aw_unit = -1;
      for (int u = 0; u < N_UNITS; u++) begin
        if (s_valid[u] && s_wstrb[u*4 +: 4] != 4'h0 && rd_addr[u] == axi_awaddr) aw_unit = u;
      end
      if (aw_unit < 0) begin
        $display("AW address %h matches no pending write request", axi_awaddr);
        end_with_failure();
      end else begin
        check({rd_name[aw_unit], " awlen"}, burst_len[aw_unit], axi_awlen);
      end
    end
  end

  initial begin
    rst       = 1'b1;
    s_valid   = '0;
    s_addr    = '0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_len     = '0;
    rd_active = '0;
    repeat (16) @(posedge clk);
    check("reset", 8'h0, {s_ready, s_last, axi_awvalid, axi_wvalid, axi_arvalid, axi_rready});
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("after reset", 8'h0,
          {s_ready, s_last, axi_awvalid, axi_wvalid, axi_arvalid, axi_rready});

    run_burst(0, "round trip write", 32'h100, 3, 4'hf);
    run_burst(0, "round trip read", 32'h100, 3, 4'h0);

    run_burst(1, "strobe write low", 32'h100, 3, 4'b0101);
    run_burst(1, "strobe write high", 32'h104, 1, 4'b1000);
    run_burst(1, "strobe read", 32'h100, 3, 4'h0);

    fork // Same start cycle, unit 1 wins first
      run_burst(0, "compete write 0", 32'h200, 7, 4'hf);
      run_burst(1, "compete write 1", 32'h300, 7, 4'hf);
    join
    run_burst(0, "compete read 0", 32'h200, 7, 4'h0);
    run_burst(1, "compete read 1", 32'h300, 7, 4'h0);

    fork
      run_burst(0, "concurrent read", 32'h200, 7, 4'h0);
      run_burst(1, "concurrent write", 32'h400, 5, 4'hf);
    join
    run_burst(1, "concurrent readback", 32'h400, 5, 4'h0);

    for (n = 0; n < 12; n++) begin
      rnd = $random(seed);
      run_burst(rnd[20], "random full write", {rnd[9:0] % 10'd1008, 2'b00}, rnd[19:16], 4'hf);
      run_burst(rnd[21], "random strobe write", {rnd[9:0] % 10'd1008, 2'b00}, rnd[19:16],
                (rnd[27:24] == 4'h0) ? 4'b0010 : rnd[27:24]);
      run_burst(rnd[22], "random read", {rnd[9:0] % 10'd1008, 2'b00}, rnd[19:16], 4'h0);
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/axi_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int DEPTH  = 1024
) (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                awvalid,
  output logic                     awready,
  input  wire logic [ADDR_W-1:0]   awaddr,
  input  wire logic                wvalid,
  output logic                     wready,
  input  wire logic [DATA_W-1:0]   wdata,
  input  wire logic [DATA_W/8-1:0] wstrb,
  input  wire logic                wlast,
  input  wire logic                arvalid,
  output logic                     arready,
  input  wire logic [ADDR_W-1:0]   araddr,
  input  wire logic [7:0]          arlen,
  output logic                     rvalid,
  input  wire logic                rready,
  output logic      [DATA_W-1:0]   rdata,
  output logic                     rlast
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [DATA_W-1:0] mem [DEPTH];
  integer            seed;
  logic              w_busy, r_busy;
  logic [IDX_W-1:0]  wptr, rptr;
  logic [7:0]        rleft; // R beats still to send after the current one

  // Ready or valid granted in about three cycles out of four
  function automatic logic coin();
    return ($random(seed) % 4) != 0;
  endfunction

  initial begin
    seed = 55211;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = {i[15:0] ^ 16'h5a5a, ~i[15:0]}; // Distinct word per address
    end
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      rdata   <= '0;
      w_busy  <= 1'b0;
      r_busy  <= 1'b0;
      wptr    <= '0;
      rptr    <= '0;
      rleft   <= '0;
    end else begin
      awready <= awvalid && !awready && !w_busy && coin();
      if (awvalid && awready) begin
        w_busy <= 1'b1;
        wptr   <= awaddr[IDX_W+1:2];
      end
      wready <= (w_busy || (awvalid && awready)) && !(wvalid && wready && wlast) && coin();
      if (wvalid && wready) begin
        for (int b = 0; b < DATA_W/8; b++) begin
          if (wstrb[b]) mem[wptr][b*8 +: 8] <= wdata[b*8 +: 8]; // Bytewise strobe
        end
        wptr <= wptr + 1'b1;
        if (wlast) w_busy <= 1'b0;
      end
      arready <= arvalid && !arready && !r_busy && coin();
      if (arvalid && arready) begin
        r_busy <= 1'b1;
        rptr   <= araddr[IDX_W+1:2];
        rleft  <= arlen;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        rlast  <= 1'b0;
        if (rlast) r_busy <= 1'b0;
      end else if (r_busy && !rvalid && coin()) begin
        rvalid <= 1'b1;
        rdata  <= mem[rptr];
        rlast  <= (rleft == 8'd0);
        rptr   <= rptr + 1'b1;
        rleft  <= rleft - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/databus_axi_top.sv
`timescale 1ns/10ps
`default_nettype none

module databus_axi_top
  import databus_pkg::*;
#(
  parameter int N_UNITS = 2,
  parameter int ADDR_W  = DEFAULT_ADDR_W,
  parameter int DATA_W  = DEFAULT_DATA_W
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // Unit databus side
  input  wire logic [N_UNITS-1:0]          s_valid,
  output logic      [N_UNITS-1:0]          s_ready,
  output logic      [N_UNITS-1:0]          s_last,
  input  wire logic [N_UNITS*ADDR_W-1:0]   s_addr,
  input  wire logic [N_UNITS*DATA_W-1:0]   s_wdata,
  input  wire logic [N_UNITS*DATA_W/8-1:0] s_wstrb,
  output logic      [DATA_W-1:0]           s_rdata,
  input  wire logic [N_UNITS*8-1:0]        s_len,
  // AXI4 master side
  output logic                             axi_awvalid,
  input  wire logic                        axi_awready,
  output logic      [ADDR_W-1:0]           axi_awaddr,
  output beat_len_t                        axi_awlen,
  output logic                             axi_wvalid,
  input  wire logic                        axi_wready,
  output logic      [DATA_W-1:0]           axi_wdata,
  output logic      [DATA_W/8-1:0]         axi_wstrb,
  output logic                             axi_wlast,
  output logic                             axi_arvalid,
  input  wire logic                        axi_arready,
  output logic      [ADDR_W-1:0]           axi_araddr,
  output beat_len_t                        axi_arlen,
  input  wire logic                        axi_rvalid,
  output logic                             axi_rready,
  input  wire logic [DATA_W-1:0]           axi_rdata,
  input  wire logic                        axi_rlast
);

  merged_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_merged_bus ();

  databus_merge #(
    .N_UNITS(N_UNITS),
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) i_databus_merge (
    .clk    (clk),
    .rst    (rst),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .s_last (s_last),
    .s_addr (s_addr),
    .s_wdata(s_wdata),
    .s_wstrb(s_wstrb),
    .s_rdata(s_rdata),
    .s_len  (s_len),
    .bus    (i_merged_bus.arb)
  );

  burst_axi_bridge #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) i_burst_axi_bridge (
    .clk        (clk),
    .rst        (rst),
    .bus        (i_merged_bus.xlat),
    .axi_awvalid(axi_awvalid),
    .axi_awready(axi_awready),
    .axi_awaddr (axi_awaddr),
    .axi_awlen  (axi_awlen),
    .axi_wvalid (axi_wvalid),
    .axi_wready (axi_wready),
    .axi_wdata  (axi_wdata),
    .axi_wstrb  (axi_wstrb),
    .axi_wlast  (axi_wlast),
    .axi_arvalid(axi_arvalid),
    .axi_arready(axi_arready),
    .axi_araddr (axi_araddr),
    .axi_arlen  (axi_arlen),
    .axi_rvalid (axi_rvalid),
    .axi_rready (axi_rready),
    .axi_rdata  (axi_rdata),
    .axi_rlast  (axi_rlast)
  );

endmodule

`default_nettype wire

// File: verilog/burst_axi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module burst_axi_bridge
  import databus_pkg::*;
#(
  parameter int ADDR_W = DEFAULT_ADDR_W,
  parameter int DATA_W = DEFAULT_DATA_W
) (
  input  wire logic                clk,
  input  wire logic                rst,
  merged_bus_if.xlat               bus,
  // AW channel
  output logic                     axi_awvalid,
  input  wire logic                axi_awready,
  output logic      [ADDR_W-1:0]   axi_awaddr,
  output beat_len_t                axi_awlen,
  // W channel
  output logic                     axi_wvalid,
  input  wire logic                axi_wready,
  output logic      [DATA_W-1:0]   axi_wdata,
  output logic      [DATA_W/8-1:0] axi_wstrb,
  output logic                     axi_wlast,
  // AR channel
  output logic                     axi_arvalid,
  input  wire logic                axi_arready,
  output logic      [ADDR_W-1:0]   axi_araddr,
  output beat_len_t                axi_arlen,
  // R channel
  input  wire logic                axi_rvalid,
  output logic                     axi_rready,
  input  wire logic [DATA_W-1:0]   axi_rdata,
  input  wire logic                axi_rlast
);

  if (DATA_W != DEFAULT_DATA_W) begin : g_width_check
    $error("burst_axi_bridge issues 4-byte beats, DATA_W must be 32");
  end

  bridge_state_e state;
  beat_len_t     beat_cnt; // W beats already accepted

  // Request fields are held steady by the unit for the whole burst
  assign axi_awaddr = bus.waddr;
  assign axi_awlen  = bus.wlen;
  assign axi_wdata  = bus.wdata;
  assign axi_wstrb  = bus.wstrb;
  assign axi_araddr = bus.raddr;
  assign axi_arlen  = bus.rlen;
  assign bus.rdata  = axi_rdata;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= ST_IDLE;
      axi_awvalid <= 1'b0;
      axi_arvalid <= 1'b0;
      beat_cnt    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (bus.wvalid) begin // Writes go first
            axi_awvalid <= 1'b1;
            state       <= ST_WADDR;
          end else if (bus.rvalid) begin
            axi_arvalid <= 1'b1;
            state       <= ST_RADDR;
          end
        end
        ST_WADDR: begin
          if (axi_awready) begin
            axi_awvalid <= 1'b0;
            state       <= ST_WDATA;
          end
        end
        ST_WDATA: begin
          if (axi_wvalid && axi_wready) begin
            if (bus.wlast) begin
              beat_cnt <= '0;
              state    <= ST_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        ST_RADDR: begin
          if (axi_arready) begin
            axi_arvalid <= 1'b0;
            state       <= ST_RDATA;
          end
        end
        ST_RDATA: begin
          if (axi_rvalid && axi_rready && axi_rlast) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Data phases follow the memory handshake combinationally
  always_comb begin
    axi_wvalid = 1'b0;
    bus.wready = 1'b0;
    bus.wlast  = 1'b0;
    axi_rready = 1'b0;
    bus.rready = 1'b0;
    bus.rlast  = 1'b0;
    if (state == ST_WDATA) begin
      axi_wvalid = bus.wvalid;
      bus.wready = axi_wready;
      bus.wlast  = (beat_cnt == bus.wlen);
    end
    if (state == ST_RDATA) begin
      axi_rready = bus.rvalid;
      bus.rready = axi_rvalid;
      bus.rlast  = axi_rlast;
    end
  end

  assign axi_wlast = bus.wlast;

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr) && $stable(axi_awlen));

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr) && $stable(axi_arlen));

  // W beats stay inside the data state and never run past the burst length
  a_w_in_data: assert property (@(posedge clk) disable iff (rst)
    axi_wvalid |-> state == ST_WDATA && beat_cnt <= bus.wlen);

endmodule

`default_nettype wire

// File: verilog/databus_merge.sv
`timescale 1ns/10ps
`default_nettype none

module databus_merge
  import databus_pkg::*;
#(
  parameter int N_UNITS = 2,
  parameter int ADDR_W  = DEFAULT_ADDR_W,
  parameter int DATA_W  = DEFAULT_DATA_W
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [N_UNITS-1:0]            s_valid,
  output logic      [N_UNITS-1:0]            s_ready,
  output logic      [N_UNITS-1:0]            s_last,
  input  wire logic [N_UNITS*ADDR_W-1:0]     s_addr,
  input  wire logic [N_UNITS*DATA_W-1:0]     s_wdata,
  input  wire logic [N_UNITS*DATA_W/8-1:0]   s_wstrb,
  output logic      [DATA_W-1:0]             s_rdata,
  input  wire logic [N_UNITS*8-1:0]          s_len,
  merged_bus_if.arb                          bus
);

  localparam int STRB_W = DATA_W/8;
  localparam int IDX_W  = $clog2(N_UNITS);

  typedef logic [IDX_W-1:0] unit_idx_t;

  logic [ADDR_W-1:0] u_addr  [N_UNITS];
  logic [DATA_W-1:0] u_wdata [N_UNITS];
  logic [STRB_W-1:0] u_wstrb [N_UNITS];
  beat_len_t         u_len   [N_UNITS];

  logic      w_running, r_running; // Direction busy with a burst
  unit_idx_t w_sel, r_sel;         // Granted unit per direction
  logic      w_req_any, r_req_any;
  unit_idx_t w_req, r_req;
  logic      w_xfer, r_xfer;

  for (genvar g = 0; g < N_UNITS; g++) begin : g_unpack
    assign u_addr[g]  = s_addr[g*ADDR_W +: ADDR_W];
    assign u_wdata[g] = s_wdata[g*DATA_W +: DATA_W];
    assign u_wstrb[g] = s_wstrb[g*STRB_W +: STRB_W];
    assign u_len[g]   = s_len[g*8 +: 8];
  end

  // Later index overwrites earlier, so the highest requester wins
  always_comb begin
    w_req_any = 1'b0;
    r_req_any = 1'b0;
    w_req     = '0;
    r_req     = '0;
    for (int i = 0; i < N_UNITS; i++) begin
      if (s_valid[i]) begin
        if (|u_wstrb[i]) begin // Any strobe bit means write
          w_req_any = 1'b1;
          w_req     = unit_idx_t'(i);
        end else begin
          r_req_any = 1'b1;
          r_req     = unit_idx_t'(i);
        end
      end
    end
  end

  assign w_xfer = bus.wvalid && bus.wready;
  assign r_xfer = bus.rvalid && bus.rready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_running <= 1'b0;
      w_sel     <= '0;
      r_running <= 1'b0;
      r_sel     <= '0;
    end else begin
      if (!w_running && w_req_any) begin
        w_running <= 1'b1;
        w_sel     <= w_req;
      end else if (w_running && w_xfer && bus.wlast) begin
        w_running <= 1'b0; // Free after last beat
      end
      if (!r_running && r_req_any) begin
        r_running <= 1'b1;
        r_sel     <= r_req;
      end else if (r_running && r_xfer && bus.rlast) begin
        r_running <= 1'b0;
      end
    end
  end

  // Steer granted unit onto the merged channels
  assign bus.wvalid = w_running && s_valid[w_sel];
  assign bus.waddr  = u_addr[w_sel];
  assign bus.wdata  = u_wdata[w_sel];
  assign bus.wstrb  = u_wstrb[w_sel];
  assign bus.wlen   = u_len[w_sel];
  assign bus.rvalid = r_running && s_valid[r_sel];
  assign bus.raddr  = u_addr[r_sel];
  assign bus.rlen   = u_len[r_sel];

  assign s_rdata = bus.rdata; // Shared by all units

  for (genvar g = 0; g < N_UNITS; g++) begin : g_decode
    logic w_hit, r_hit;
    assign w_hit      = w_running && (w_sel == unit_idx_t'(g));
    assign r_hit      = r_running && (r_sel == unit_idx_t'(g));
    assign s_ready[g] = (w_hit && bus.wready) || (r_hit && bus.rready);
    assign s_last[g]  = (w_hit && bus.wlast) || (r_hit && bus.rlast);
  end

  // Bridge carries one burst at a time so at most one unit sees ready
  a_ready_grants: assert property (@(posedge clk) disable iff (rst)
    $onehot0(s_ready));

endmodule

`default_nettype wire

// File: verilog/merged_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface merged_bus_if
  import databus_pkg::*;
#(
  parameter int ADDR_W = DEFAULT_ADDR_W,
  parameter int DATA_W = DEFAULT_DATA_W
) ();

  // Write group
  logic                  wvalid;
  logic [ADDR_W-1:0]     waddr;
  logic [DATA_W-1:0]     wdata;
  logic [DATA_W/8-1:0]   wstrb;
  beat_len_t             wlen;
  logic                  wready; // One W beat accepted
  logic                  wlast;  // Current beat closes the burst

  // Read group
  logic                  rvalid;
  logic [ADDR_W-1:0]     raddr;
  beat_len_t             rlen;
  logic                  rready; // One R beat on rdata
  logic [DATA_W-1:0]     rdata;
  logic                  rlast;

  modport arb (
    output wvalid, waddr, wdata, wstrb, wlen,
    input  wready, wlast,
    output rvalid, raddr, rlen,
    input  rready, rdata, rlast
  );

  modport xlat (
    input  wvalid, waddr, wdata, wstrb, wlen,
    output wready, wlast,
    input  rvalid, raddr, rlen,
    output rready, rdata, rlast
  );

endinterface

`default_nettype wire

// File: verilog/databus_pkg.sv
`default_nettype none

package databus_pkg;

  // Burst length as carried on the databus and on AxLEN
  typedef logic [7:0] beat_len_t; // Beats minus one

  // Bridge sequencing, one burst in flight at a time
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WADDR, // AW handshake pending
    ST_WDATA, // W beats flowing
    ST_RADDR, // AR handshake pending
    ST_RDATA  // R beats flowing
  } bridge_state_e;

  localparam int DEFAULT_ADDR_W = 32;
  localparam int DEFAULT_DATA_W = 32; // Bridge beat size is fixed at 4 bytes

endpackage

`default_nettype wire
